// ==== hw/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address and word widths
`define DC_ADDR_W 32
`define DC_DATA_W 64
`define DC_MASK_W 8

// line geometry, two ways of 64 sets
`define DC_LINE_W 256
`define DC_SETS 64
`define DC_INDEX_W 6
`define DC_OFFSET_W 5
`define DC_WORD_SEL_W 2
`define DC_TAG_W 21

// words per refill burst
`define DC_BEATS 4

`endif

// ==== hw/dcache_pkg.sv ====
`default_nettype none

`include "dcache_params.svh"

package dcachePkg;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } memOp_e;

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LOOKUP = 3'd1,
    WRBACK = 3'd2,
    RDREQ  = 3'd3,
    REFILL = 3'd4
  } cacheState_e;

  // tag | index | word in line | byte in word
  typedef struct packed {
    logic [`DC_TAG_W-1:0]                    tag;
    logic [`DC_INDEX_W-1:0]                  index;
    logic [`DC_WORD_SEL_W-1:0]               wordSel;
    logic [`DC_OFFSET_W-`DC_WORD_SEL_W-1:0]  byteOff;
  } dcAddr_t;

  typedef struct packed {
    memOp_e                 op;
    dcAddr_t                addr;
    logic [`DC_DATA_W-1:0]  wdata;
    logic [`DC_MASK_W-1:0]  wmask;
  } coreReq_t;

  typedef logic [`DC_LINE_W-1:0] lineData_t;

  // victim write-back, line-aligned address plus the whole line
  typedef struct packed {
    logic [`DC_ADDR_W-1:0]  addr;
    lineData_t              data;
  } wrBack_t;

endpackage

`default_nettype wire

// ==== hw/dcacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheCtrl import dcachePkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   reqValid_i,
  input  wire coreReq_t               req_i,
  input  wire logic                   rspReady_i,
  input  wire logic                   hit_i,
  input  wire logic                   hitWay_i,
  input  wire logic                   victimWay_i,
  input  wire logic                   victimDirty_i,
  input  wire logic [`DC_TAG_W-1:0]   victimTag_i,
  input  wire logic                   memRdReady_i,
  input  wire logic                   memWrReady_i,
  input  wire logic                   lineDone_i,
  output logic                        reqReady_o,
  output logic                        rspValid_o,
  output coreReq_t                    reqLatch_o,
  output logic                        storeWe_o,
  output logic                        refillWe_o,
  output logic                        wayWe_o,
  output logic                        refillStart_o,
  output logic                        memRdValid_o,
  output logic [`DC_ADDR_W-1:0]       memRdAddr_o,
  output logic                        memWrValid_o,
  output logic [`DC_ADDR_W-1:0]       memWrAddr_o
);

  cacheState_e state;
  cacheState_e nextState;
  coreReq_t    reqLatch;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  // request is only taken in IDLE, so the latch holds for the whole miss
  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      reqLatch <= req_i;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (reqValid_i) begin
          nextState = LOOKUP;
        end
      end
      LOOKUP: begin
        // stay here until the core takes the response
        if (hit_i) begin
          if (rspReady_i) begin
            nextState = IDLE;
          end
        end else if (victimDirty_i) begin
          nextState = WRBACK;
        end else begin
          nextState = RDREQ;
        end
      end
      WRBACK: begin
        if (memWrReady_i) begin
          nextState = RDREQ;
        end
      end
      RDREQ: begin
        if (memRdReady_i) begin
          nextState = REFILL;
        end
      end
      REFILL: begin
        // lookup again, it hits after the line write
        if (lineDone_i) begin
          nextState = LOOKUP;
        end
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  assign reqReady_o = (state == IDLE);
  assign rspValid_o = (state == LOOKUP) && hit_i;
  assign reqLatch_o = reqLatch;

  // store bytes land on the response handshake
  assign storeWe_o  = rspValid_o && rspReady_i && (reqLatch.op == STORE);
  assign refillWe_o = (state == REFILL) && lineDone_i;
  assign wayWe_o    = (state == LOOKUP) ? hitWay_i : victimWay_i;

  assign memRdValid_o  = (state == RDREQ);
  assign refillStart_o = memRdValid_o && memRdReady_i;
  assign memRdAddr_o   = {reqLatch.addr.tag, reqLatch.addr.index, {`DC_OFFSET_W{1'b0}}};

  // write-back goes to the victim's own tag
  assign memWrValid_o = (state == WRBACK);
  assign memWrAddr_o  = {victimTag_i, reqLatch.addr.index, {`DC_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

// ==== hw/dcacheTagStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheTagStore import dcachePkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`DC_INDEX_W-1:0]   index_i,
  input  wire logic [`DC_TAG_W-1:0]     tag_i,
  input  wire logic                     storeWe_i,
  input  wire logic                     refillWe_i,
  input  wire logic                     wayWe_i,
  output logic                          hit_o,
  output logic                          hitWay_o,
  output logic                          victimWay_o,
  output logic                          victimDirty_o,
  output logic [`DC_TAG_W-1:0]          victimTag_o
);

  logic [`DC_TAG_W-1:0]  tagArr [2][`DC_SETS];
  logic [1:0][`DC_SETS-1:0] validArr;
  logic [1:0][`DC_SETS-1:0] dirtyArr;
  logic                  replToggle;
  logic [1:0]            wayHit;

  // tag compare on both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validArr[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // invalid way first, otherwise the toggle
  always_comb begin
    if (!validArr[0][index_i]) begin
      victimWay_o = 1'b0;
    end else if (!validArr[1][index_i]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = replToggle;
    end
  end

  assign victimDirty_o = dirtyArr[victimWay_o][index_i];
  assign victimTag_o   = tagArr[victimWay_o][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr   <= '0;
      dirtyArr   <= '0;
      replToggle <= 1'b0;
    end else if (refillWe_i) begin
      // fresh line is clean
      validArr[wayWe_i][index_i] <= 1'b1;
      dirtyArr[wayWe_i][index_i] <= 1'b0;
      replToggle                 <= ~replToggle;
    end else if (storeWe_i) begin
      dirtyArr[wayWe_i][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refillWe_i) begin
      tagArr[wayWe_i][index_i] <= tag_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dcacheDataStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheDataStore import dcachePkg::*; (
  input  wire logic                       clk,
  input  wire logic [`DC_INDEX_W-1:0]     index_i,
  input  wire logic [`DC_WORD_SEL_W-1:0]  wordSel_i,
  input  wire logic [`DC_DATA_W-1:0]      wdata_i,
  input  wire logic [`DC_MASK_W-1:0]      wmask_i,
  input  wire logic                       storeWe_i,
  input  wire logic                       refillWe_i,
  input  wire logic                       wayWe_i,
  input  wire logic                       hitWay_i,
  input  wire logic                       victimWay_i,
  input  wire lineData_t                  refillLine_i,
  output logic [`DC_DATA_W-1:0]           rdWord_o,
  output lineData_t                       victimLine_o
);

  lineData_t lineArr [2][`DC_SETS];
  lineData_t hitLine;
  lineData_t storeLine;

  assign hitLine      = lineArr[hitWay_i][index_i];
  assign rdWord_o     = hitLine[wordSel_i*`DC_DATA_W +: `DC_DATA_W];
  assign victimLine_o = lineArr[victimWay_i][index_i];

  // merge masked bytes into the current line
  always_comb begin
    storeLine = lineArr[wayWe_i][index_i];
    for (int b = 0; b < `DC_MASK_W; b++) begin
      if (wmask_i[b]) begin
        storeLine[wordSel_i*`DC_DATA_W + b*8 +: 8] = wdata_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refillWe_i) begin
      lineArr[wayWe_i][index_i] <= refillLine_i;
    end else if (storeWe_i) begin
      lineArr[wayWe_i][index_i] <= storeLine;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dcacheRefill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheRefill import dcachePkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   refillStart_i,
  input  wire logic                   beatValid_i,
  input  wire logic [`DC_DATA_W-1:0]  beatData_i,
  input  wire logic                   beatLast_i,
  output lineData_t                   line_o,
  output logic                        lineDone_o
);

  logic [$clog2(`DC_BEATS)-1:0] beatCnt;
  lineData_t                    lineBuf;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt    <= '0;
      lineDone_o <= 1'b0;
    end else begin
      // one cycle after the last beat
      lineDone_o <= beatValid_i && beatLast_i;
      if (refillStart_i) begin
        beatCnt <= '0;
      end else if (beatValid_i) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineBuf[beatCnt*`DC_DATA_W +: `DC_DATA_W] <= beatData_i;
    end
  end

  assign line_o = lineBuf;

endmodule

`default_nettype wire

// ==== hw/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache import dcachePkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   reqValid_i,
  input  wire coreReq_t               req_i,
  output logic                        reqReady_o,
  output logic                        rspValid_o,
  output logic [`DC_DATA_W-1:0]       rspData_o,
  input  wire logic                   rspReady_i,
  output logic                        memRdValid_o,
  output logic [`DC_ADDR_W-1:0]       memRdAddr_o,
  input  wire logic                   memRdReady_i,
  input  wire logic                   memRdDataValid_i,
  input  wire logic [`DC_DATA_W-1:0]  memRdData_i,
  input  wire logic                   memRdLast_i,
  output logic                        memWrValid_o,
  output wrBack_t                     memWr_o,
  input  wire logic                   memWrReady_i
);

  coreReq_t               reqLatch;
  logic                   hit, hitWay, victimWay, victimDirty;
  logic [`DC_TAG_W-1:0]   victimTag;
  logic                   storeWe, refillWe, wayWe, refillStart, lineDone;
  logic [`DC_ADDR_W-1:0]  memWrAddr;
  logic [`DC_DATA_W-1:0]  rdWord;
  lineData_t              victimLine;
  lineData_t              refillLine;

  dcacheCtrl uCtrl (
    .clk, .rst_n, .reqValid_i, .req_i, .rspReady_i,
    .hit_i(hit), .hitWay_i(hitWay), .victimWay_i(victimWay),
    .victimDirty_i(victimDirty), .victimTag_i(victimTag),
    .memRdReady_i, .memWrReady_i, .lineDone_i(lineDone),
    .reqReady_o, .rspValid_o, .reqLatch_o(reqLatch),
    .storeWe_o(storeWe), .refillWe_o(refillWe), .wayWe_o(wayWe),
    .refillStart_o(refillStart), .memRdValid_o, .memRdAddr_o,
    .memWrValid_o, .memWrAddr_o(memWrAddr)
  );

  dcacheTagStore uTags (
    .clk, .rst_n, .index_i(reqLatch.addr.index), .tag_i(reqLatch.addr.tag),
    .storeWe_i(storeWe), .refillWe_i(refillWe), .wayWe_i(wayWe),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  dcacheDataStore uData (
    .clk, .index_i(reqLatch.addr.index), .wordSel_i(reqLatch.addr.wordSel),
    .wdata_i(reqLatch.wdata), .wmask_i(reqLatch.wmask),
    .storeWe_i(storeWe), .refillWe_i(refillWe), .wayWe_i(wayWe),
    .hitWay_i(hitWay), .victimWay_i(victimWay), .refillLine_i(refillLine),
    .rdWord_o(rdWord), .victimLine_o(victimLine)
  );

  dcacheRefill uRefill (
    .clk, .rst_n, .refillStart_i(refillStart),
    .beatValid_i(memRdDataValid_i), .beatData_i(memRdData_i),
    .beatLast_i(memRdLast_i), .line_o(refillLine), .lineDone_o(lineDone)
  );

  // stores answer with zero
  assign rspData_o = (reqLatch.op == LOAD) ? rdWord : '0;

  assign memWr_o.addr = memWrAddr;
  assign memWr_o.data = victimLine;

endmodule

`default_nettype wire

// ==== tb/dcacheMemModel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheMemModel import dcachePkg::*; (
  input  wire logic                   clk,
  input  wire logic                   memRdValid_i,
  input  wire logic [`DC_ADDR_W-1:0]  memRdAddr_i,
  output logic                        memRdReady_o,
  output logic                        memRdDataValid_o,
  output logic [`DC_DATA_W-1:0]       memRdData_o,
  output logic                        memRdLast_o,
  input  wire logic                   memWrValid_i,
  input  wire wrBack_t                memWr_i,
  output logic                        memWrReady_o,
  output int                          rdCount_o,
  output int                          wrCount_o
);

  logic [`DC_DATA_W-1:0] mem [logic [`DC_ADDR_W-1:0]];
  integer                seed = 32'h9199;
  logic [`DC_ADDR_W-1:0] rdAddr;
  wrBack_t               wrReq;

  // untouched words follow the address pattern
  function automatic logic [`DC_DATA_W-1:0] memWord(input logic [`DC_ADDR_W-1:0] a);
    return mem.exists(a) ? mem[a] : {a ^ 32'h5a5a_c3c3, ~a};
  endfunction

  initial begin
    memRdReady_o = 1'b0;
    memRdDataValid_o = 1'b0;
    memRdData_o = '0;
    memRdLast_o = 1'b0;
    memWrReady_o = 1'b0;
    rdCount_o = 0;
    wrCount_o = 0;
    forever begin
      @(negedge clk);
      if (memWrReady_o) begin
        // valid was held, so the last rising edge took the line
        memWrReady_o = 1'b0;
        wrCount_o++;
        for (int b = 0; b < `DC_BEATS; b++) begin
          mem[wrReq.addr + b*8] = wrReq.data[b*`DC_DATA_W +: `DC_DATA_W];
        end
      end else if (memRdReady_o) begin
        memRdReady_o = 1'b0;
        rdCount_o++;
        // lowest word first, random gaps between beats
        for (int b = 0; b < `DC_BEATS; b++) begin
          repeat ($random(seed) & 3) @(negedge clk);
          memRdDataValid_o = 1'b1;
          memRdData_o = memWord(rdAddr + b*8);
          memRdLast_o = (b == `DC_BEATS-1);
          @(negedge clk);
          memRdDataValid_o = 1'b0;
          memRdLast_o = 1'b0;
        end
      end else if (memWrValid_i) begin
        wrReq = memWr_i;
        memWrReady_o = ($random(seed) & 3) != 0;
      end else if (memRdValid_i) begin
        rdAddr = memRdAddr_i;
        memRdReady_o = ($random(seed) & 3) != 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/dcacheTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcacheTb import dcachePkg::*; ();

  localparam int TIMEOUT = 1000;

  logic                  clk;
  logic                  rst_n;
  logic                  reqValid, reqReady, rspValid, rspReady;
  coreReq_t              req;
  logic [`DC_DATA_W-1:0] rspData, expData, prevRspData;
  logic                  memRdValid, memRdReady, memRdDataValid, memRdLast;
  logic [`DC_ADDR_W-1:0] memRdAddr, expRdAddr;
  logic [`DC_DATA_W-1:0] memRdData;
  logic                  memWrValid, memWrReady, expectHit;
  wrBack_t               memWr;
  lineData_t             refWrLine;
  int                    rdCount, wrCount, errCount, passCount, failCount;
  bit                    timedOut;
  integer                seed = 32'h9199;
  logic [`DC_DATA_W-1:0] refMem [logic [`DC_ADDR_W-1:0]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  dcache dut (
    .clk, .rst_n, .reqValid_i(reqValid), .req_i(req), .reqReady_o(reqReady),
    .rspValid_o(rspValid), .rspData_o(rspData), .rspReady_i(rspReady),
    .memRdValid_o(memRdValid), .memRdAddr_o(memRdAddr), .memRdReady_i(memRdReady),
    .memRdDataValid_i(memRdDataValid), .memRdData_i(memRdData), .memRdLast_i(memRdLast),
    .memWrValid_o(memWrValid), .memWr_o(memWr), .memWrReady_i(memWrReady)
  );

  dcacheMemModel uMem (
    .clk, .memRdValid_i(memRdValid), .memRdAddr_i(memRdAddr), .memRdReady_o(memRdReady),
    .memRdDataValid_o(memRdDataValid), .memRdData_o(memRdData), .memRdLast_o(memRdLast),
    .memWrValid_i(memWrValid), .memWr_i(memWr), .memWrReady_o(memWrReady),
    .rdCount_o(rdCount), .wrCount_o(wrCount)
  );

  // a word never stored keeps the fill pattern
  function automatic logic [63:0] refWord(input logic [31:0] a);
    return refMem.exists(a) ? refMem[a] : {a ^ 32'h5a5a_c3c3, ~a};
  endfunction

  function automatic lineData_t refLine(input logic [31:0] a);
    lineData_t l;
    for (int b = 0; b < `DC_BEATS; b++) begin
      l[b*`DC_DATA_W +: `DC_DATA_W] = refWord({a[31:5], 5'd0} + b*8);
    end
    return l;
  endfunction

  task automatic reportMismatch(input string name, input logic [255:0] exp, got);
    errCount++;
    $display("[FAIL] %s exp %0h got %0h", name, exp, got);
  endtask

  task automatic reportProblem(input string msg);
    errCount++;
    $display("error: %s", msg);
  endtask

  always @(posedge clk) prevRspData <= rspData;
  always @(negedge clk) refWrLine = refLine(memWr.addr);

  assert property (@(posedge clk) $rose(rst_n) |->
      {reqReady, rspValid, memRdValid, memWrValid} == 4'b1000)
    else reportMismatch("{reqReady_o,rspValid_o,memRdValid_o,memWrValid_o}", 8,
      $sampled({reqReady, rspValid, memRdValid, memWrValid}));
  assert property (@(posedge clk) disable iff (!rst_n) memRdValid |-> memRdAddr == expRdAddr)
    else reportMismatch("memRdAddr_o", $sampled(expRdAddr), $sampled(memRdAddr));
  assert property (@(posedge clk) disable iff (!rst_n) expectHit |-> !memRdValid)
    else reportProblem("memory read issued for a line that should hit");
  assert property (@(posedge clk) disable iff (!rst_n) rspValid && rspReady |-> rspData == expData)
    else reportMismatch("rspData_o", $sampled(expData), $sampled(rspData));
  // response must not move while the core stalls
  assert property (@(posedge clk) disable iff (!rst_n)
      rspValid && !rspReady |=> rspValid && rspData == prevRspData)
    else reportMismatch("rspData_o held", $sampled(prevRspData), $sampled(rspData));
  // victim sits in the request's set on a line boundary
  assert property (@(posedge clk) disable iff (!rst_n)
      memWrValid |-> memWr.addr[10:0] == expRdAddr[10:0])
    else reportMismatch("memWr_o.addr[10:0]", $sampled(expRdAddr[10:0]),
      $sampled(memWr.addr[10:0]));
  assert property (@(posedge clk) disable iff (!rst_n) memWrValid |-> memWr.data == refWrLine)
    else reportMismatch("memWr_o.data", $sampled(refWrLine), $sampled(memWr.data));

  // one request and its response from a falling edge
  task automatic access(input memOp_e op, input logic [31:0] addr, input logic [63:0] wdata,
                        input logic [7:0] wmask, input bit stall);
    logic [31:0] wa;
    logic [63:0] merged;
    int          cnt;
    bit          hs;
    if (!timedOut) begin
      wa = {addr[31:3], 3'd0};
      merged = refWord(wa);
      for (int b = 0; b < `DC_MASK_W; b++) begin
        if (op == STORE && wmask[b]) merged[b*8 +: 8] = wdata[b*8 +: 8];
      end
      if (op == STORE) refMem[wa] = merged;
      expData = (op == LOAD) ? merged : '0;
      expRdAddr = {addr[31:5], 5'd0};
      req = '{op, wa, wdata, wmask};
      reqValid = 1'b1;
      cnt = 0;
      while (!reqReady && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
      end
      if (!reqReady) begin
        reqValid = 1'b0;
        reportProblem("timeout waiting for reqReady_o");
        timedOut = 1'b1;
      end else begin
        @(negedge clk);
        reqValid = 1'b0;
        cnt = 0;
        hs = 1'b0;
        while (!hs && cnt < TIMEOUT) begin
          rspReady = !stall || ($random(seed) & 1);
          hs = rspValid && rspReady;
          @(negedge clk);
          cnt++;
        end
        rspReady = 1'b0;
        if (!hs) begin
          reportProblem("timeout waiting for rspValid_o");
          timedOut = 1'b1;
        end
      end
    end
  endtask

  task automatic endTest(input string name, input int errBefore);
    if (errCount == errBefore) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: %0d errors", name, errCount - errBefore);
    end
  endtask

  initial begin
    int          errBefore, cntBefore;
    logic [31:0] a;
    logic [63:0] wd;
    logic [7:0]  wm;
    memOp_e      op;
    rst_n = 1'b0;
    reqValid = 1'b0;
    req = '0;
    rspReady = 1'b0;
    expectHit = 1'b0;
    expData = '0;
    expRdAddr = '0;
    errCount = 0;
    passCount = 0;
    failCount = 0;
    timedOut = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    endTest("reset state", 0);

    errBefore = errCount;
    cntBefore = rdCount;
    access(LOAD, 32'h0000_4048, '0, '0, 1'b0);
    assert (rdCount == cntBefore + 1) else reportProblem("first load made no memory read");
    endTest("load miss refill", errBefore);

    errBefore = errCount;
    expectHit = 1'b1;
    access(LOAD, 32'h0000_4058, '0, '0, 1'b0);
    expectHit = 1'b0;
    endTest("load hit", errBefore);

    errBefore = errCount;
    access(STORE, 32'h0000_4050, 64'h1122_3344_5566_7788, 8'h5a, 1'b0);
    access(LOAD, 32'h0000_4050, '0, '0, 1'b0);
    endTest("byte-masked store", errBefore);

    // three dirty lines on index 4
    errBefore = errCount;
    cntBefore = wrCount;
    for (int t = 1; t <= 3; t++) begin
      wd = {$random(seed), $random(seed)};
      access(STORE, (t << 16) | 32'h80, wd, 8'hff, 1'b0);
    end
    assert (wrCount > cntBefore) else reportProblem("no write-back after three dirty lines");
    endTest("dirty eviction", errBefore);

    // four tags on four sets keeps evictions busy
    errBefore = errCount;
    for (int i = 0; i < 200; i++) begin
      a = 32'h0020_0000 | ($random(seed) & 32'h0000_1878);
      op = ($random(seed) & 1) ? STORE : LOAD;
      wd = {$random(seed), $random(seed)};
      wm = $random(seed);
      access(op, a, wd, wm, 1'b1);
    end
    endTest("random mix", errBefore);

    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0 && errCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dcache.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcacheCtrl.sv
hw/dcacheTagStore.sv
hw/dcacheDataStore.sv
hw/dcacheRefill.sv
hw/dcache.sv
tb/dcacheMemModel.sv
tb/dcacheTb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - hw
    files:
      - hw/dcache_pkg.sv
      - hw/dcacheCtrl.sv
      - hw/dcacheTagStore.sv
      - hw/dcacheDataStore.sv
      - hw/dcacheRefill.sv
      - hw/dcache.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/dcacheMemModel.sv
      - tb/dcacheTb.sv
